// ==== source/tile_pkg.sv ====
package tile_pkg;

   typedef logic [31:0] adr_t;
   typedef logic [31:0] dat_t;
   typedef logic [3:0]  sel_t;

   typedef enum logic [1:0] {
      SLAVE_DM,
      SLAVE_BOOT,
      SLAVE_NONE
   } slave_e;

   localparam int NR_MASTERS = 2;
   localparam int MIDX_W     = $clog2(NR_MASTERS);    // Grant index width

   // Address map, compared on the top address bits
   localparam int                        DM_RANGE_WIDTH   = 1;
   localparam logic [DM_RANGE_WIDTH-1:0] DM_RANGE_MATCH   = 1'b0;
   localparam int                          BOOT_RANGE_WIDTH = 4;
   localparam logic [BOOT_RANGE_WIDTH-1:0] BOOT_RANGE_MATCH = 4'hf;

   localparam int LMEM_SIZE = 1024;                    // Bytes
   localparam int LMEM_AW   = 8;                       // Word address bits

   localparam int BOOT_WORDS = 8;
   localparam int BOOT_AW    = $clog2(BOOT_WORDS);

   // Boot image, small startup loop
   localparam dat_t BOOT_IMAGE [0:BOOT_WORDS-1] = '{
      32'h1800_0000,
      32'ha840_0100,
      32'h1860_0000,
      32'ha863_0400,
      32'hd403_1000,
      32'h9c63_0004,
      32'h03ff_fffe,
      32'h1500_0000
   };

endpackage

// ==== source/wb_arbiter.sv ====
`timescale 1ns/1ns

module wb_arbiter
   import tile_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic [NR_MASTERS-1:0] m_cyc_i,
   input  logic [NR_MASTERS-1:0] m_stb_i,
   input  logic [NR_MASTERS-1:0] m_we_i,
   input  adr_t [NR_MASTERS-1:0] m_adr_i,
   input  sel_t [NR_MASTERS-1:0] m_sel_i,
   input  dat_t [NR_MASTERS-1:0] m_dat_i,
   output logic [NR_MASTERS-1:0] m_ack_o,
   output logic [NR_MASTERS-1:0] m_err_o,
   output dat_t [NR_MASTERS-1:0] m_dat_o,
   output logic                  g_cyc_o,
   output logic                  g_stb_o,
   output logic                  g_we_o,
   output adr_t                  g_adr_o,
   output sel_t                  g_sel_o,
   output dat_t                  g_dat_o,
   input  logic                  g_ack_i,
   input  logic                  g_err_i,
   input  dat_t                  g_dat_i
);

   logic              busy_q;
   logic [MIDX_W-1:0] grant_q;
   logic [MIDX_W-1:0] ptr_q;
   logic [MIDX_W-1:0] pick;
   logic              pick_vld;
   logic [MIDX_W-1:0] ptr_nxt;
   logic [MIDX_W-1:0] gnt;
   logic              gnt_vld;

   // Search from the pointer, lowest offset wins
   always_comb begin
      int idx;
      pick     = ptr_q;
      pick_vld = 1'b0;
      for (int i = NR_MASTERS - 1; i >= 0; i--) begin
         idx = (int'(ptr_q) + i) % NR_MASTERS;
         if (m_cyc_i[idx]) begin
            pick     = MIDX_W'(idx);
            pick_vld = 1'b1;
         end
      end
   end

   assign ptr_nxt = (pick == MIDX_W'(NR_MASTERS - 1)) ? '0 : pick + 1'b1;
   assign gnt     = busy_q ? grant_q : pick;    // Idle bus grants at once
   assign gnt_vld = busy_q | pick_vld;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         busy_q  <= 1'b0;
         grant_q <= '0;
         ptr_q   <= '0;
      end else if (busy_q) begin
         if (!m_cyc_i[grant_q]) begin
            busy_q <= 1'b0;                     // Released after cyc drops
         end
      end else if (pick_vld) begin
         busy_q  <= 1'b1;
         grant_q <= pick;
         ptr_q   <= ptr_nxt;
      end
   end

   assign g_cyc_o = gnt_vld & m_cyc_i[gnt];
   assign g_stb_o = g_cyc_o & m_stb_i[gnt];
   assign g_we_o  = m_we_i[gnt];
   assign g_adr_o = m_adr_i[gnt];
   assign g_sel_o = m_sel_i[gnt];
   assign g_dat_o = m_dat_i[gnt];

   // Responses go to the granted master only
   always_comb begin
      for (int m = 0; m < NR_MASTERS; m++) begin
         m_ack_o[m] = gnt_vld && (gnt == MIDX_W'(m)) && g_ack_i;
         m_err_o[m] = gnt_vld && (gnt == MIDX_W'(m)) && g_err_i;
         m_dat_o[m] = (gnt == MIDX_W'(m)) ? g_dat_i : '0;
      end
   end

endmodule

// ==== source/wb_slave_mux.sv ====
`timescale 1ns/1ns

module wb_slave_mux
   import tile_pkg::*;
(
   input  logic clk,
   input  logic reset_i,
   input  logic g_cyc_i,
   input  logic g_stb_i,
   input  logic g_we_i,
   input  adr_t g_adr_i,
   input  sel_t g_sel_i,
   input  dat_t g_dat_i,
   output logic g_ack_o,
   output logic g_err_o,
   output dat_t g_dat_o,
   output logic dm_stb_o,
   output logic dm_we_o,
   output adr_t dm_adr_o,
   output sel_t dm_sel_o,
   output dat_t dm_dat_o,
   input  logic dm_ack_i,
   input  dat_t dm_dat_i,
   output logic boot_stb_o,
   output adr_t boot_adr_o,
   input  logic boot_ack_i,
   input  dat_t boot_dat_i,
   output logic snoop_en_o,
   output adr_t snoop_adr_o
);

   slave_e slave;
   logic   req;
   logic   err_q;
   logic   snoop_en_q;
   adr_t   snoop_adr_q;

   // Address decode on the top bits
   always_comb begin
      if (g_adr_i[31 -: DM_RANGE_WIDTH] == DM_RANGE_MATCH) begin
         slave = SLAVE_DM;
      end else if (g_adr_i[31 -: BOOT_RANGE_WIDTH] == BOOT_RANGE_MATCH) begin
         slave = SLAVE_BOOT;
      end else begin
         slave = SLAVE_NONE;
      end
   end

   assign req = g_cyc_i & g_stb_i;

   assign dm_stb_o   = req && (slave == SLAVE_DM);
   assign dm_we_o    = g_we_i;
   assign dm_adr_o   = g_adr_i;
   assign dm_sel_o   = g_sel_i;
   assign dm_dat_o   = g_dat_i;
   assign boot_stb_o = req && (slave == SLAVE_BOOT);
   assign boot_adr_o = g_adr_i;

   // Only one slave acks at a time
   assign g_ack_o = dm_ack_i | boot_ack_i;
   assign g_err_o = err_q;
   assign g_dat_o = dm_ack_i ? dm_dat_i : (boot_ack_i ? boot_dat_i : '0);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         err_q      <= 1'b0;
         snoop_en_q <= 1'b0;
      end else begin
         err_q      <= req && (slave == SLAVE_NONE) && !err_q;   // One cycle pulse
         snoop_en_q <= dm_stb_o && g_we_i && !dm_ack_i;          // Lines up with RAM ack
      end
   end

   always_ff @(posedge clk) begin
      if (dm_stb_o && g_we_i && !dm_ack_i) begin
         snoop_adr_q <= g_adr_i;
      end
   end

   assign snoop_en_o  = snoop_en_q;
   assign snoop_adr_o = snoop_adr_q;

endmodule

// ==== source/wb_sram_sp.sv ====
`timescale 1ns/1ns

module wb_sram_sp
   import tile_pkg::*;
(
   input  logic clk,
   input  logic reset_i,
   input  logic stb_i,
   input  logic we_i,
   input  adr_t adr_i,
   input  sel_t sel_i,
   input  dat_t dat_i,
   output logic ack_o,
   output dat_t dat_o
);

   dat_t               mem [0:LMEM_SIZE/4-1];
   logic [LMEM_AW-1:0] widx;
   logic               access;

   assign widx   = adr_i[LMEM_AW+1:2];        // Upper bits alias
   assign access = stb_i & ~ack_o;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;                     // Never two acks in a row
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (we_i) begin
            for (int b = 0; b < 4; b++) begin
               if (sel_i[b]) begin
                  mem[widx][8*b +: 8] <= dat_i[8*b +: 8];
               end
            end
         end
         dat_o <= mem[widx];                  // Valid with ack
      end
   end

endmodule

// ==== source/bootrom.sv ====
`timescale 1ns/1ns

module bootrom
   import tile_pkg::*;
(
   input  logic clk,
   input  logic reset_i,
   input  logic stb_i,
   input  adr_t adr_i,
   output logic ack_o,
   output dat_t dat_o
);

   logic [BOOT_AW-1:0] widx;
   logic               access;

   // Image repeats across the whole range
   assign widx   = adr_i[BOOT_AW+1:2];
   assign access = stb_i & ~ack_o;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;          // Writes are acked too
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         dat_o <= BOOT_IMAGE[widx];
      end
   end

endmodule

// ==== source/compute_tile_bus.sv ====
`timescale 1ns/1ns

module compute_tile_bus
   import tile_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic [NR_MASTERS-1:0] m_cyc_i,
   input  logic [NR_MASTERS-1:0] m_stb_i,
   input  logic [NR_MASTERS-1:0] m_we_i,
   input  adr_t [NR_MASTERS-1:0] m_adr_i,
   input  sel_t [NR_MASTERS-1:0] m_sel_i,
   input  dat_t [NR_MASTERS-1:0] m_dat_i,
   output logic [NR_MASTERS-1:0] m_ack_o,
   output logic [NR_MASTERS-1:0] m_err_o,
   output dat_t [NR_MASTERS-1:0] m_dat_o,
   output logic                  snoop_en_o,
   output adr_t                  snoop_adr_o
);

   // Granted request
   logic g_cyc;
   logic g_stb;
   logic g_we;
   adr_t g_adr;
   sel_t g_sel;
   dat_t g_dat;
   logic g_ack;
   logic g_err;
   dat_t g_dat_r;

   // Slave side
   logic dm_stb;
   logic dm_we;
   adr_t dm_adr;
   sel_t dm_sel;
   dat_t dm_dat;
   logic dm_ack;
   dat_t dm_dat_r;
   logic boot_stb;
   adr_t boot_adr;
   logic boot_ack;
   dat_t boot_dat_r;

   wb_arbiter u_arbiter (
      .clk     (clk),
      .reset_i (reset_i),
      .m_cyc_i (m_cyc_i),
      .m_stb_i (m_stb_i),
      .m_we_i  (m_we_i),
      .m_adr_i (m_adr_i),
      .m_sel_i (m_sel_i),
      .m_dat_i (m_dat_i),
      .m_ack_o (m_ack_o),
      .m_err_o (m_err_o),
      .m_dat_o (m_dat_o),
      .g_cyc_o (g_cyc),
      .g_stb_o (g_stb),
      .g_we_o  (g_we),
      .g_adr_o (g_adr),
      .g_sel_o (g_sel),
      .g_dat_o (g_dat),
      .g_ack_i (g_ack),
      .g_err_i (g_err),
      .g_dat_i (g_dat_r)
   );

   wb_slave_mux u_slave_mux (
      .clk         (clk),
      .reset_i     (reset_i),
      .g_cyc_i     (g_cyc),
      .g_stb_i     (g_stb),
      .g_we_i      (g_we),
      .g_adr_i     (g_adr),
      .g_sel_i     (g_sel),
      .g_dat_i     (g_dat),
      .g_ack_o     (g_ack),
      .g_err_o     (g_err),
      .g_dat_o     (g_dat_r),
      .dm_stb_o    (dm_stb),
      .dm_we_o     (dm_we),
      .dm_adr_o    (dm_adr),
      .dm_sel_o    (dm_sel),
      .dm_dat_o    (dm_dat),
      .dm_ack_i    (dm_ack),
      .dm_dat_i    (dm_dat_r),
      .boot_stb_o  (boot_stb),
      .boot_adr_o  (boot_adr),
      .boot_ack_i  (boot_ack),
      .boot_dat_i  (boot_dat_r),
      .snoop_en_o  (snoop_en_o),
      .snoop_adr_o (snoop_adr_o)
   );

   wb_sram_sp u_ram (
      .clk     (clk),
      .reset_i (reset_i),
      .stb_i   (dm_stb),
      .we_i    (dm_we),
      .adr_i   (dm_adr),
      .sel_i   (dm_sel),
      .dat_i   (dm_dat),
      .ack_o   (dm_ack),
      .dat_o   (dm_dat_r)
   );

   bootrom u_bootrom (
      .clk     (clk),
      .reset_i (reset_i),
      .stb_i   (boot_stb),
      .adr_i   (boot_adr),
      .ack_o   (boot_ack),
      .dat_o   (boot_dat_r)
   );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk_o,
   output logic reset_o
);

   localparam int HALF_PERIOD  = 20;          // 40 ns clock
   localparam int RESET_CYCLES = 5;

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;                          // Released between edges
   end

endmodule

// ==== sim/tb_compute_tile_bus.sv ====
`timescale 1ns/1ns

module tb_compute_tile_bus
   import tile_pkg::*;
();

   localparam int TIMEOUT   = 20;             // Cycles allowed per wait
   localparam int MEM_WORDS = LMEM_SIZE / 4;

   logic                  clk;
   logic                  reset;
   logic [NR_MASTERS-1:0] m_cyc;
   logic [NR_MASTERS-1:0] m_stb;
   logic [NR_MASTERS-1:0] m_we;
   adr_t [NR_MASTERS-1:0] m_adr;
   sel_t [NR_MASTERS-1:0] m_sel;
   dat_t [NR_MASTERS-1:0] m_dat;
   logic [NR_MASTERS-1:0] m_ack;
   logic [NR_MASTERS-1:0] m_err;
   dat_t [NR_MASTERS-1:0] m_rdat;
   logic                  snoop_en;
   adr_t                  snoop_adr;

   int   seed;
   int   n_checks;
   int   n_errors;
   dat_t ref_mem [0:MEM_WORDS-1];             // Expected memory contents

   tb_clock_gen u_clock_gen (
      .clk_o   (clk),
      .reset_o (reset)
   );

   compute_tile_bus u_dut (
      .clk         (clk),
      .reset_i     (reset),
      .m_cyc_i     (m_cyc),
      .m_stb_i     (m_stb),
      .m_we_i      (m_we),
      .m_adr_i     (m_adr),
      .m_sel_i     (m_sel),
      .m_dat_i     (m_dat),
      .m_ack_o     (m_ack),
      .m_err_o     (m_err),
      .m_dat_o     (m_rdat),
      .snoop_en_o  (snoop_en),
      .snoop_adr_o (snoop_adr)
   );

   function automatic logic is_mem(input adr_t adr);
      return adr < 32'h8000_0000;
   endfunction

   function automatic logic is_boot(input adr_t adr);
      return adr >= 32'hf000_0000;
   endfunction

   function automatic int mem_index(input adr_t adr);
      return int'((adr >> 2) % MEM_WORDS);     // Memory repeats in its range
   endfunction

   function automatic dat_t rand_word();
      return dat_t'($random(seed));
   endfunction

   function automatic adr_t rand_mem_adr();
      logic [31:0] r;
      r = $random(seed);
      return {1'b0, r[30:2], 2'b00};
   endfunction

   task automatic model_write(input adr_t adr, input sel_t sel, input dat_t wdat);
      int idx;
      idx = mem_index(adr);
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            ref_mem[idx][8*b +: 8] = wdat[8*b +: 8];
         end
      end
   endtask

   task automatic check_dat(input string name, input dat_t exp, input dat_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("MISMATCH at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   // One uncontended transfer sampled on falling edges before driving
   task automatic bus_access(input int m, input logic we, input adr_t adr, input sel_t sel,
                             input dat_t wdat, output dat_t rdat);
      logic ack;
      logic err;
      logic snp;
      adr_t snp_adr;
      int   cycles;
      logic mapped;
      mapped = is_mem(adr) || is_boot(adr);
      ack    = 1'b0;
      err    = 1'b0;
      cycles = 0;
      rdat   = '0;
      @(negedge clk);
      m_cyc[m] = 1'b1;
      m_stb[m] = 1'b1;
      m_we[m]  = we;
      m_adr[m] = adr;
      m_sel[m] = sel;
      m_dat[m] = wdat;
      while (!ack && !err && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
         ack     = m_ack[m];
         err     = m_err[m];
         rdat    = m_rdat[m];
         snp     = snoop_en;
         snp_adr = snoop_adr;
         check_bit("snoop_en_o", (cycles == 1) && we && is_mem(adr), snp);
      end
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
      if (!ack && !err) begin
         n_errors++;
         $display("Timeout at %0t ns: master %0d got neither ack nor err for address %h",
                  $time, m, adr);
      end else begin
         check_bit($sformatf("m_ack_o[%0d]", m), mapped, ack);
         check_bit($sformatf("m_err_o[%0d]", m), !mapped, err);
         check_bit("response after one cycle", 1'b1, cycles == 1);
         if (we && is_mem(adr)) begin
            check_dat("snoop_adr_o", adr, snp_adr);
            model_write(adr, sel, wdat);
         end
      end
   endtask

   task automatic read_mem_check(input int m, input adr_t adr);
      dat_t rdat;
      bus_access(m, 1'b0, adr, 4'hf, '0, rdat);
      check_dat($sformatf("m_dat_o[%0d] at %h", m, adr), ref_mem[mem_index(adr)], rdat);
   endtask

   task automatic read_boot_check(input int m, input adr_t adr);
      dat_t rdat;
      int   idx;
      idx = int'(((adr - 32'hf000_0000) >> 2) % BOOT_WORDS);
      bus_access(m, 1'b0, adr, 4'hf, '0, rdat);
      check_dat($sformatf("m_dat_o[%0d] at %h", m, adr), BOOT_IMAGE[idx], rdat);
   endtask

   // Both masters raise a request on the same falling edge
   task automatic run_contended(input logic we, input adr_t [NR_MASTERS-1:0] adr,
                                input dat_t [NR_MASTERS-1:0] wdat,
                                output dat_t [NR_MASTERS-1:0] rdat, output int first);
      logic [NR_MASTERS-1:0] done;
      logic [NR_MASTERS-1:0] ack;
      logic [NR_MASTERS-1:0] err;
      dat_t [NR_MASTERS-1:0] dat;
      logic                  snp;
      int                    cycles;
      done   = '0;
      first  = -1;
      cycles = 0;
      rdat   = '0;
      @(negedge clk);
      for (int m = 0; m < NR_MASTERS; m++) begin
         m_cyc[m] = 1'b1;
         m_stb[m] = 1'b1;
         m_we[m]  = we;
         m_adr[m] = adr[m];
         m_sel[m] = 4'hf;
         m_dat[m] = wdat[m];
      end
      while (done != '1 && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
         ack = m_ack;
         err = m_err;
         dat = m_rdat;
         snp = snoop_en;
         check_bit("snoop_en_o", we && (ack != '0), snp);
         for (int m = 0; m < NR_MASTERS; m++) begin
            if (!done[m] && (ack[m] || err[m])) begin
               check_bit($sformatf("m_err_o[%0d]", m), 1'b0, err[m]);
               rdat[m]  = dat[m];
               done[m]  = 1'b1;
               m_cyc[m] = 1'b0;
               m_stb[m] = 1'b0;
               if (first < 0) begin
                  first = m;
               end
               if (we && ack[m]) begin
                  model_write(adr[m], 4'hf, wdat[m]);
               end
            end
         end
      end
      if (done != '1) begin
         n_errors++;
         $display("Timeout at %0t ns: contended transfers did not both complete", $time);
         m_cyc = '0;
         m_stb = '0;
      end
   endtask

   task automatic test_reset_state();
      check_bit("m_ack_o[0]", 1'b0, m_ack[0]);
      check_bit("m_ack_o[1]", 1'b0, m_ack[1]);
      check_bit("m_err_o[0]", 1'b0, m_err[0]);
      check_bit("m_err_o[1]", 1'b0, m_err[1]);
      check_bit("snoop_en_o", 1'b0, snoop_en);
   endtask

   task automatic test_contention();
      adr_t [NR_MASTERS-1:0] adr;
      dat_t [NR_MASTERS-1:0] wdat;
      dat_t [NR_MASTERS-1:0] rdat;
      int                    first;
      adr[0]  = rand_mem_adr();
      adr[1]  = adr[0] ^ 32'h4;               // Neighbouring word
      wdat[0] = rand_word();
      wdat[1] = rand_word();
      run_contended(1'b1, adr, wdat, rdat, first);
      check_bit("master 0 acked first on writes", 1'b1, first == 0);
      run_contended(1'b0, adr, '0, rdat, first);
      check_bit("master 0 acked first on reads", 1'b1, first == 0);
      check_dat("m_dat_o[0]", wdat[0], rdat[0]);
      check_dat("m_dat_o[1]", wdat[1], rdat[1]);
   endtask

   task automatic test_mem_rw();
      adr_t adr [8];
      dat_t rdat;
      for (int i = 0; i < 8; i++) begin
         adr[i] = rand_mem_adr();
         bus_access(1, 1'b1, adr[i], 4'hf, rand_word(), rdat);
      end
      for (int i = 0; i < 8; i++) begin
         read_mem_check(0, adr[i]);
      end
      read_mem_check(0, adr[0] ^ 32'h400);    // Aliased copy of the same word
      for (int i = 0; i < 4; i++) begin
         bus_access(1, 1'b1, adr[i], 4'b0101 ^ sel_t'(i), rand_word(), rdat);
         read_mem_check(0, adr[i]);
      end
   endtask

   task automatic test_bootrom();
      dat_t rdat;
      for (int i = 0; i < 2 * BOOT_WORDS; i++) begin
         read_boot_check(0, adr_t'(32'hf000_0000 + 4 * i));
      end
      bus_access(1, 1'b1, 32'hf000_0008, 4'hf, rand_word(), rdat);
      read_boot_check(0, 32'hf000_0008);
      read_boot_check(1, 32'hffff_fffc);
   endtask

   task automatic test_unmapped();
      adr_t probe;
      dat_t rdat;
      probe = 32'h1000_0000;                  // Same low bits as the holes
      bus_access(1, 1'b1, probe, 4'hf, rand_word(), rdat);
      read_mem_check(0, probe);
      bus_access(1, 1'b1, 32'h9000_0000, 4'hf, rand_word(), rdat);
      bus_access(0, 1'b0, 32'h9000_0000, 4'hf, '0, rdat);
      bus_access(0, 1'b1, 32'he000_0000, 4'hf, rand_word(), rdat);
      bus_access(1, 1'b0, 32'he000_0000, 4'hf, '0, rdat);
      read_mem_check(0, probe);
   endtask

   // Snoop checks run inside every transfer
   task automatic test_snoop();
      dat_t rdat;
      bus_access(0, 1'b1, rand_mem_adr(), 4'hf, rand_word(), rdat);
      bus_access(1, 1'b1, rand_mem_adr(), 4'h3, rand_word(), rdat);
      bus_access(0, 1'b0, rand_mem_adr(), 4'hf, '0, rdat);
      bus_access(1, 1'b0, 32'hf000_0010, 4'hf, '0, rdat);
      bus_access(0, 1'b1, 32'hf000_0014, 4'hf, rand_word(), rdat);
      bus_access(1, 1'b1, 32'hc000_0000, 4'hf, rand_word(), rdat);
   endtask

   task automatic report_test(input string name, input int errors_before);
      $display("%-12s %s, %0d errors", name,
               (n_errors == errors_before) ? "passed" : "FAILED", n_errors - errors_before);
   endtask

   initial begin
      int errs;
      int n;
      seed     = 32'hab3f_62db;
      n_checks = 0;
      n_errors = 0;
      m_cyc    = '0;
      m_stb    = '0;
      m_we     = '0;
      m_adr    = '0;
      m_sel    = '0;
      m_dat    = '0;
      n        = 0;
      while (reset !== 1'b0 && n < 4 * TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (reset !== 1'b0) begin
         n_errors++;
         $display("Reset was never released");
      end
      @(negedge clk);
      errs = n_errors;
      test_reset_state();
      report_test("reset", errs);
      errs = n_errors;
      test_contention();
      report_test("contention", errs);
      errs = n_errors;
      test_mem_rw();
      report_test("mem_rw", errs);
      errs = n_errors;
      test_bootrom();
      report_test("bootrom", errs);
      errs = n_errors;
      test_unmapped();
      report_test("unmapped", errs);
      errs = n_errors;
      test_snoop();
      report_test("snoop", errs);
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
source/tile_pkg.sv
source/wb_arbiter.sv
source/wb_slave_mux.sv
source/wb_sram_sp.sv
source/bootrom.sv
source/compute_tile_bus.sv
sim/tb_clock_gen.sv
sim/tb_compute_tile_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the tile bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_compute_tile_bus
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
